// ==== verilog/qproc_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared widths, payload types, request classes and
// selector codes for the peripheral interface
////////////////////////////////////////////////////////////

package qproc_pkg;

   // Peripheral data word
   localparam int unsigned DT_W = 32;

   // Two-word peripheral payload, word 0 sits in the upper half
   typedef logic [0:1][DT_W-1:0] dt_pair_t;

   // One input port sample
   typedef logic [63:0] port_dt_t;

   // User control byte and its operation field
   typedef logic [7:0] usr_ctrl_t;
   typedef logic [4:0] usr_op_t;

   // Internal class, taken from ctrl[7:4]
   localparam logic [3:0] OPC_FLAG = 4'd1;

   // External classes, taken from ctrl[7:5]
   localparam logic [2:0] EXT_NET = 3'd4;
   localparam logic [2:0] EXT_COM = 3'd5;
   localparam logic [2:0] EXT_P1  = 3'd6;
   localparam logic [2:0] EXT_P2  = 3'd7;

   typedef logic [1:0] ext_idx_t;

   ////////////////////////////////////////////////////////////
   // Read-data source codes, unlisted values read w_dt
   typedef logic [3:0] src_sel_t;
   localparam src_sel_t SRC_W_DT = 4'd0;
   localparam src_sel_t SRC_NET  = 4'd1;
   localparam src_sel_t SRC_COM  = 4'd2;
   localparam src_sel_t SRC_P1   = 4'd3;
   localparam src_sel_t SRC_P2   = 4'd4;
   localparam src_sel_t SRC_PORT = 4'd5;

   // Flag source codes
   typedef logic [2:0] flg_sel_t;
   localparam flg_sel_t FLG_INT    = 3'd0;
   localparam flg_sel_t FLG_HOST   = 3'd1;
   localparam flg_sel_t FLG_EXT    = 3'd2;
   localparam flg_sel_t FLG_PORT   = 3'd3;
   localparam flg_sel_t FLG_NET    = 3'd4;
   localparam flg_sel_t FLG_COM    = 3'd5;
   localparam flg_sel_t FLG_P1     = 3'd6;
   localparam flg_sel_t FLG_P2_NEW = 3'd7;

   // Status word port fields
   localparam int unsigned ST_PORT_ANY = 15;
   localparam int unsigned ST_PORT_LSB = 16;

endpackage

// ==== verilog/usr_op_decoder.sv ====
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// Registered decode of user requests into peripheral
// enables, flag strobes and latched operands
////////////////////////////////////////////////////////////

module usr_op_decoder import qproc_pkg::*; (
   input  logic            c_clk_i,
   input  logic            ps_rst_ni,
   input  logic            usr_en_i,
   input  usr_ctrl_t       usr_ctrl_i,
   input  logic [DT_W-1:0] usr_a_dt_i,
   input  logic [DT_W-1:0] usr_b_dt_i,
   input  logic [DT_W-1:0] usr_c_dt_i,
   input  logic [DT_W-1:0] usr_d_dt_i,
   output logic [3:0]      ext_en_o,
   output logic            int_flag_set_o,
   output logic            int_flag_clr_o,
   output logic            int_flag_inv_o,
   output logic [DT_W-1:0] periph_a_dt_o,
   output logic [DT_W-1:0] periph_b_dt_o,
   output logic [DT_W-1:0] periph_c_dt_o,
   output logic [DT_W-1:0] periph_d_dt_o,
   output usr_op_t         periph_op_o
);

   logic [3:0] int_cls;
   logic [2:0] ext_cls;
   usr_op_t    usr_op;
   ext_idx_t   ext_idx;
   logic       ext_hit;
   logic       flag_hit;
   logic [3:0] ext_en_d;

   assign int_cls = usr_ctrl_i[7:4];
   assign ext_cls = usr_ctrl_i[7:5];
   assign usr_op  = usr_ctrl_i[4:0];

   // External class to peripheral index
   always_comb begin
      ext_hit = 1'b1;
      ext_idx = 2'd0;
      case (ext_cls)
         EXT_NET: ext_idx = 2'd0;
         EXT_COM: ext_idx = 2'd1;
         EXT_P1:  ext_idx = 2'd2;
         EXT_P2:  ext_idx = 2'd3;
         default: ext_hit = 1'b0;
      endcase
   end

   // Time, arith and div classes fall through to nothing
   assign flag_hit = usr_en_i && (int_cls == OPC_FLAG);

   always_comb begin
      ext_en_d = '0;
      if (usr_en_i && ext_hit) begin
         ext_en_d[ext_idx] = 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // Single-cycle strobes
   always_ff @(posedge c_clk_i or negedge ps_rst_ni) begin
      if (!ps_rst_ni) begin
         ext_en_o       <= '0;
         int_flag_set_o <= 1'b0;
         int_flag_clr_o <= 1'b0;
         int_flag_inv_o <= 1'b0;
      end else begin
         ext_en_o       <= ext_en_d;
         int_flag_set_o <= flag_hit && usr_op[0];
         int_flag_clr_o <= flag_hit && usr_op[1];
         int_flag_inv_o <= flag_hit && usr_op[2];
      end
   end

   // Operands and operation hold until the next request
   always_ff @(posedge c_clk_i or negedge ps_rst_ni) begin
      if (!ps_rst_ni) begin
         periph_a_dt_o <= '0;
         periph_b_dt_o <= '0;
         periph_c_dt_o <= '0;
         periph_d_dt_o <= '0;
         periph_op_o   <= '0;
      end else if (usr_en_i) begin
         periph_a_dt_o <= usr_a_dt_i;
         periph_b_dt_o <= usr_b_dt_i;
         periph_c_dt_o <= usr_c_dt_i;
         periph_d_dt_o <= usr_d_dt_i;
         periph_op_o   <= usr_op;
      end
   end

   // One request class active per cycle
   a_one_class : assert property (@(posedge c_clk_i) disable iff (!ps_rst_ni)
      $onehot0(ext_en_o) &&
      !((|ext_en_o) && (int_flag_set_o || int_flag_clr_o || int_flag_inv_o)));

endmodule

// ==== verilog/resp_capture.sv ====
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// Response latch with new-data marker, generic payload
////////////////////////////////////////////////////////////

module resp_capture import qproc_pkg::*; #(
   parameter type PAYLOAD_T = dt_pair_t
) (
   input  logic     c_clk_i,
   input  logic     ps_rst_ni,
   input  logic     vld_i,
   input  PAYLOAD_T dt_i,
   input  logic     clr_i,
   output PAYLOAD_T dt_o,
   output logic     new_o
);

   PAYLOAD_T dt_q;
   logic     new_q;

   // Valid beats a clear in the same cycle
   always_ff @(posedge c_clk_i or negedge ps_rst_ni) begin
      if (!ps_rst_ni) begin
         new_q <= 1'b0;
      end else if (vld_i) begin
         new_q <= 1'b1;
      end else if (clr_i) begin
         new_q <= 1'b0;
      end
   end

   // Last payload stays put across a clear
   always_ff @(posedge c_clk_i or negedge ps_rst_ni) begin
      if (!ps_rst_ni) begin
         dt_q <= '0;
      end else if (vld_i) begin
         dt_q <= dt_i;
      end
   end

   assign dt_o  = dt_q;
   assign new_o = new_q;

   // Every accepted response is flagged on the next cycle
   a_new_after_vld : assert property (@(posedge c_clk_i) disable iff (!ps_rst_ni)
      vld_i |=> new_o);

endmodule

// ==== verilog/src_select.sv ====
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// Flag registers, ready tracking, status word and the
// flag and read-data source multiplexers
////////////////////////////////////////////////////////////

module src_select import qproc_pkg::*; #(
   parameter int unsigned IN_PORT_QTY = 1
) (
   input  logic                   c_clk_i,
   input  logic                   ps_rst_ni,
   input  logic                   int_flag_set_i,
   input  logic                   int_flag_clr_i,
   input  logic                   int_flag_inv_i,
   input  logic                   host_flag_set_i,
   input  logic                   host_flag_clr_i,
   input  logic                   ext_flag_i,
   input  logic                   net_flag_i,
   input  logic                   com_flag_i,
   input  logic                   p1_flag_i,
   input  logic [3:0]             rdy_i,
   input  logic [3:0]             new_i,
   input  logic [IN_PORT_QTY-1:0] port_new_i,
   input  port_dt_t               port0_dt_i,
   input  dt_pair_t               net_dt_i,
   input  dt_pair_t               com_dt_i,
   input  dt_pair_t               p1_dt_i,
   input  dt_pair_t               p2_dt_i,
   input  dt_pair_t               w_dt_i,
   input  flg_sel_t               flg_sel_i,
   input  src_sel_t               src_sel_i,
   output logic                   flag_o,
   output logic [31:0]            status_o,
   output dt_pair_t               r_dt_o
);

   logic        int_flag_r;
   logic        host_flag_r;
   logic [1:0]  ext_flag_sync;
   logic [3:0]  rdy_r;
   logic [15:0] port_new_w;
   logic        port_any;

   ////////////////////////////////////////////////////////////
   // Flag registers

   always_ff @(posedge c_clk_i or negedge ps_rst_ni) begin
      if (!ps_rst_ni) begin
         int_flag_r  <= 1'b0;
         host_flag_r <= 1'b0;
      end else begin
         if (int_flag_set_i) begin
            int_flag_r <= 1'b1;
         end else if (int_flag_clr_i) begin
            int_flag_r <= 1'b0;
         end else if (int_flag_inv_i) begin
            int_flag_r <= ~int_flag_r;
         end
         // Host set wins over clear
         if (host_flag_set_i) begin
            host_flag_r <= 1'b1;
         end else if (host_flag_clr_i) begin
            host_flag_r <= 1'b0;
         end
      end
   end

   // Async external flag, two-flop synchronizer
   always_ff @(posedge c_clk_i or negedge ps_rst_ni) begin
      if (!ps_rst_ni) begin
         ext_flag_sync <= 2'b00;
      end else begin
         ext_flag_sync <= {ext_flag_sync[0], ext_flag_i};
      end
   end

   // Peripherals count as ready out of reset
   always_ff @(posedge c_clk_i or negedge ps_rst_ni) begin
      if (!ps_rst_ni) begin
         rdy_r <= 4'hF;
      end else begin
         rdy_r <= rdy_i;
      end
   end

   ////////////////////////////////////////////////////////////
   // Status word

   always_comb begin
      port_new_w = '0;
      port_new_w[IN_PORT_QTY-1:0] = port_new_i;
   end

   assign port_any = |port_new_i;

   // Ready/new pairs from bit 4 up, net first
   always_comb begin
      status_o = '0;
      for (int k = 0; k < 4; k++) begin
         status_o[4 + 2*k] = rdy_r[k];
         status_o[5 + 2*k] = new_i[k];
      end
      status_o[ST_PORT_ANY]       = port_any;
      status_o[ST_PORT_LSB +: 16] = port_new_w;
   end

   ////////////////////////////////////////////////////////////
   // Source multiplexers

   always_comb begin
      flag_o = int_flag_r;
      case (flg_sel_i)
         FLG_INT:    flag_o = int_flag_r;
         FLG_HOST:   flag_o = host_flag_r;
         FLG_EXT:    flag_o = ext_flag_sync[1];
         FLG_PORT:   flag_o = port_any;
         FLG_NET:    flag_o = net_flag_i;
         FLG_COM:    flag_o = com_flag_i;
         FLG_P1:     flag_o = p1_flag_i;
         FLG_P2_NEW: flag_o = new_i[3];
         default:    flag_o = int_flag_r;
      endcase
   end

   // Port read puts the low half out as word 0
   always_comb begin
      case (src_sel_i)
         SRC_W_DT: r_dt_o = w_dt_i;
         SRC_NET:  r_dt_o = net_dt_i;
         SRC_COM:  r_dt_o = com_dt_i;
         SRC_P1:   r_dt_o = p1_dt_i;
         SRC_P2:   r_dt_o = p2_dt_i;
         SRC_PORT: r_dt_o = {port0_dt_i[31:0], port0_dt_i[63:32]};
         default:  r_dt_o = w_dt_i;
      endcase
   end

   // Internal flag only moves on a decoder strobe
   a_int_flag_stable : assert property (@(posedge c_clk_i) disable iff (!ps_rst_ni)
      !(int_flag_set_i || int_flag_clr_i || int_flag_inv_i) |=> $stable(int_flag_r));

endmodule

// ==== verilog/qproc_periph_top.sv ====
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// Peripheral side of the processor, decoder to selector
////////////////////////////////////////////////////////////

module qproc_periph_top import qproc_pkg::*; #(
   parameter int unsigned IN_PORT_QTY = 1
) (
   input  logic            c_clk_i,
   input  logic            ps_rst_ni,
   // User requests from the core
   input  logic            usr_en_i,
   input  usr_ctrl_t       usr_ctrl_i,
   input  logic [DT_W-1:0] usr_a_dt_i,
   input  logic [DT_W-1:0] usr_b_dt_i,
   input  logic [DT_W-1:0] usr_c_dt_i,
   input  logic [DT_W-1:0] usr_d_dt_i,
   // Peripheral responses
   input  logic            qnet_vld_i,
   input  dt_pair_t        qnet_dt_i,
   input  logic            qnet_rdy_i,
   input  logic            qnet_clr_i,
   input  logic            qcom_vld_i,
   input  dt_pair_t        qcom_dt_i,
   input  logic            qcom_rdy_i,
   input  logic            qcom_clr_i,
   input  logic            qp1_vld_i,
   input  dt_pair_t        qp1_dt_i,
   input  logic            qp1_rdy_i,
   input  logic            qp1_clr_i,
   input  logic            qp2_vld_i,
   input  dt_pair_t        qp2_dt_i,
   input  logic            qp2_rdy_i,
   input  logic            qp2_clr_i,
   input  logic            qnet_flag_i,
   input  logic            qcom_flag_i,
   input  logic            qp1_flag_i,
   // Input ports
   input  logic            port_tvalid_i [IN_PORT_QTY],
   input  port_dt_t        port_tdata_i  [IN_PORT_QTY],
   input  logic            port_clr_i,
   // Flags and selectors
   input  logic            ext_flag_i,
   input  logic            host_flag_set_i,
   input  logic            host_flag_clr_i,
   input  flg_sel_t        flg_sel_i,
   input  src_sel_t        src_sel_i,
   input  dt_pair_t        w_dt_i,
   // Peripheral requests
   output logic            qnet_en_o,
   output logic            qcom_en_o,
   output logic            qp1_en_o,
   output logic            qp2_en_o,
   output logic [DT_W-1:0] periph_a_dt_o,
   output logic [DT_W-1:0] periph_b_dt_o,
   output logic [DT_W-1:0] periph_c_dt_o,
   output logic [DT_W-1:0] periph_d_dt_o,
   output usr_op_t         periph_op_o,
   // Core view
   output logic            flag_o,
   output logic [31:0]     status_o,
   output dt_pair_t        core_r_dt_o
);

   logic [3:0]             ext_en;
   logic                   int_flag_set;
   logic                   int_flag_clr;
   logic                   int_flag_inv;
   dt_pair_t               net_dt;
   dt_pair_t               com_dt;
   dt_pair_t               p1_dt;
   dt_pair_t               p2_dt;
   logic [3:0]             resp_new;
   logic [IN_PORT_QTY-1:0] port_new;
   port_dt_t               port_dt [IN_PORT_QTY];

   usr_op_decoder u_decoder (
      .c_clk_i        (c_clk_i),
      .ps_rst_ni      (ps_rst_ni),
      .usr_en_i       (usr_en_i),
      .usr_ctrl_i     (usr_ctrl_i),
      .usr_a_dt_i     (usr_a_dt_i),
      .usr_b_dt_i     (usr_b_dt_i),
      .usr_c_dt_i     (usr_c_dt_i),
      .usr_d_dt_i     (usr_d_dt_i),
      .ext_en_o       (ext_en),
      .int_flag_set_o (int_flag_set),
      .int_flag_clr_o (int_flag_clr),
      .int_flag_inv_o (int_flag_inv),
      .periph_a_dt_o  (periph_a_dt_o),
      .periph_b_dt_o  (periph_b_dt_o),
      .periph_c_dt_o  (periph_c_dt_o),
      .periph_d_dt_o  (periph_d_dt_o),
      .periph_op_o    (periph_op_o)
   );

   assign qnet_en_o = ext_en[0];
   assign qcom_en_o = ext_en[1];
   assign qp1_en_o  = ext_en[2];
   assign qp2_en_o  = ext_en[3];

   ////////////////////////////////////////////////////////////
   // Response capture, one per peripheral, own clear each

   resp_capture #(.PAYLOAD_T(dt_pair_t)) u_cap_net (
      .c_clk_i(c_clk_i), .ps_rst_ni(ps_rst_ni), .vld_i(qnet_vld_i),
      .dt_i(qnet_dt_i), .clr_i(qnet_clr_i), .dt_o(net_dt), .new_o(resp_new[0])
   );

   resp_capture #(.PAYLOAD_T(dt_pair_t)) u_cap_com (
      .c_clk_i(c_clk_i), .ps_rst_ni(ps_rst_ni), .vld_i(qcom_vld_i),
      .dt_i(qcom_dt_i), .clr_i(qcom_clr_i), .dt_o(com_dt), .new_o(resp_new[1])
   );

   resp_capture #(.PAYLOAD_T(dt_pair_t)) u_cap_p1 (
      .c_clk_i(c_clk_i), .ps_rst_ni(ps_rst_ni), .vld_i(qp1_vld_i),
      .dt_i(qp1_dt_i), .clr_i(qp1_clr_i), .dt_o(p1_dt), .new_o(resp_new[2])
   );

   resp_capture #(.PAYLOAD_T(dt_pair_t)) u_cap_p2 (
      .c_clk_i(c_clk_i), .ps_rst_ni(ps_rst_ni), .vld_i(qp2_vld_i),
      .dt_i(qp2_dt_i), .clr_i(qp2_clr_i), .dt_o(p2_dt), .new_o(resp_new[3])
   );

   // Input ports share one clear
   for (genvar i = 0; i < IN_PORT_QTY; i++) begin : g_port
      resp_capture #(.PAYLOAD_T(port_dt_t)) u_cap_port (
         .c_clk_i(c_clk_i), .ps_rst_ni(ps_rst_ni), .vld_i(port_tvalid_i[i]),
         .dt_i(port_tdata_i[i]), .clr_i(port_clr_i), .dt_o(port_dt[i]),
         .new_o(port_new[i])
      );
   end

   src_select #(.IN_PORT_QTY(IN_PORT_QTY)) u_select (
      .c_clk_i         (c_clk_i),
      .ps_rst_ni       (ps_rst_ni),
      .int_flag_set_i  (int_flag_set),
      .int_flag_clr_i  (int_flag_clr),
      .int_flag_inv_i  (int_flag_inv),
      .host_flag_set_i (host_flag_set_i),
      .host_flag_clr_i (host_flag_clr_i),
      .ext_flag_i      (ext_flag_i),
      .net_flag_i      (qnet_flag_i),
      .com_flag_i      (qcom_flag_i),
      .p1_flag_i       (qp1_flag_i),
      .rdy_i           ({qp2_rdy_i, qp1_rdy_i, qcom_rdy_i, qnet_rdy_i}),
      .new_i           (resp_new),
      .port_new_i      (port_new),
      .port0_dt_i      (port_dt[0]),
      .net_dt_i        (net_dt),
      .com_dt_i        (com_dt),
      .p1_dt_i         (p1_dt),
      .p2_dt_i         (p2_dt),
      .w_dt_i          (w_dt_i),
      .flg_sel_i       (flg_sel_i),
      .src_sel_i       (src_sel_i),
      .flag_o          (flag_o),
      .status_o        (status_o),
      .r_dt_o          (core_r_dt_o)
   );

endmodule

// ==== verif/tb_qproc_periph.sv ====
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// Testbench for the peripheral top with stimulus, reference
// model, output assertions, watchdog and closing report
////////////////////////////////////////////////////////////

module tb_qproc_periph import qproc_pkg::*; ();

   localparam int CLK_PERIOD = 100;
   localparam int RST_CYC    = 5;
   localparam int PORT_QTY   = 2;
   localparam int NUM_RAND   = 400;
   // Reset, idle sweep, directed cases, random and drain
   localparam int STIM_CYC   = RST_CYC + 8 + 24 + NUM_RAND + 4;

   logic            clk = 1'b0;
   logic            rst_n;
   logic            usr_en;
   usr_ctrl_t       usr_ctrl;
   logic [DT_W-1:0] usr_a;
   logic [DT_W-1:0] usr_b;
   logic [DT_W-1:0] usr_c;
   logic [DT_W-1:0] usr_d;
   // Peripheral signals indexed net, com, p1, p2
   logic [3:0]      resp_vld;
   logic [3:0]      resp_rdy;
   logic [3:0]      resp_clr;
   dt_pair_t        resp_dt [4];
   logic [2:0]      periph_flag;
   logic            port_tvalid [PORT_QTY];
   port_dt_t        port_tdata [PORT_QTY];
   logic            port_clr;
   logic            ext_flag;
   logic            host_set;
   logic            host_clr;
   flg_sel_t        flg_sel;
   src_sel_t        src_sel;
   dt_pair_t        w_dt;

   logic [3:0]      en_out;
   logic [DT_W-1:0] opnd_a;
   logic [DT_W-1:0] opnd_b;
   logic [DT_W-1:0] opnd_c;
   logic [DT_W-1:0] opnd_d;
   usr_op_t         op_out;
   logic            flag_out;
   logic [31:0]     status_out;
   dt_pair_t        rdata_out;

   // Reference model state
   logic [3:0]          exp_en;
   usr_op_t             exp_op;
   logic [4*DT_W-1:0]   exp_opnd;
   logic                exp_fset;
   logic                exp_fclr;
   logic                exp_finv;
   logic                exp_int_flag;
   logic                exp_host_flag;
   logic [1:0]          exp_ext_q;
   logic [3:0]          exp_rdy;
   logic [3:0]          exp_new;
   dt_pair_t            exp_dt [4];
   logic [PORT_QTY-1:0] exp_port_new;
   port_dt_t            exp_port_dt [PORT_QTY];
   logic [31:0]         exp_status;
   logic                exp_flag;
   dt_pair_t            exp_rdata;
   int                  errors = 0;

   always #(CLK_PERIOD/2) clk = ~clk;

   qproc_periph_top #(.IN_PORT_QTY(PORT_QTY)) u_dut (
      .c_clk_i(clk), .ps_rst_ni(rst_n), .usr_en_i(usr_en), .usr_ctrl_i(usr_ctrl),
      .usr_a_dt_i(usr_a), .usr_b_dt_i(usr_b), .usr_c_dt_i(usr_c), .usr_d_dt_i(usr_d),
      .qnet_vld_i(resp_vld[0]), .qnet_dt_i(resp_dt[0]), .qnet_rdy_i(resp_rdy[0]),
      .qnet_clr_i(resp_clr[0]),
      .qcom_vld_i(resp_vld[1]), .qcom_dt_i(resp_dt[1]), .qcom_rdy_i(resp_rdy[1]),
      .qcom_clr_i(resp_clr[1]),
      .qp1_vld_i(resp_vld[2]), .qp1_dt_i(resp_dt[2]), .qp1_rdy_i(resp_rdy[2]),
      .qp1_clr_i(resp_clr[2]),
      .qp2_vld_i(resp_vld[3]), .qp2_dt_i(resp_dt[3]), .qp2_rdy_i(resp_rdy[3]),
      .qp2_clr_i(resp_clr[3]),
      .qnet_flag_i(periph_flag[0]), .qcom_flag_i(periph_flag[1]),
      .qp1_flag_i(periph_flag[2]),
      .port_tvalid_i(port_tvalid), .port_tdata_i(port_tdata), .port_clr_i(port_clr),
      .ext_flag_i(ext_flag), .host_flag_set_i(host_set), .host_flag_clr_i(host_clr),
      .flg_sel_i(flg_sel), .src_sel_i(src_sel), .w_dt_i(w_dt),
      .qnet_en_o(en_out[0]), .qcom_en_o(en_out[1]), .qp1_en_o(en_out[2]),
      .qp2_en_o(en_out[3]),
      .periph_a_dt_o(opnd_a), .periph_b_dt_o(opnd_b), .periph_c_dt_o(opnd_c),
      .periph_d_dt_o(opnd_d), .periph_op_o(op_out),
      .flag_o(flag_out), .status_o(status_out), .core_r_dt_o(rdata_out)
   );

   ////////////////////////////////////////////////////////////
   // Reference model

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         exp_en        <= '0;
         exp_op        <= '0;
         exp_opnd      <= '0;
         exp_fset      <= 1'b0;
         exp_fclr      <= 1'b0;
         exp_finv      <= 1'b0;
         exp_int_flag  <= 1'b0;
         exp_host_flag <= 1'b0;
         exp_ext_q     <= '0;
         exp_rdy       <= 4'hF;
         exp_new       <= '0;
         exp_port_new  <= '0;
         for (int k = 0; k < 4; k++) begin
            exp_dt[k] <= '0;
         end
         for (int i = 0; i < PORT_QTY; i++) begin
            exp_port_dt[i] <= '0;
         end
      end else begin
         // Classes 4 to 7 map to net, com, p1, p2
         exp_en <= '0;
         if (usr_en && usr_ctrl[7]) begin
            exp_en[usr_ctrl[6:5]] <= 1'b1;
         end
         exp_fset <= usr_en && (usr_ctrl[7:4] == 4'h1) && usr_ctrl[0];
         exp_fclr <= usr_en && (usr_ctrl[7:4] == 4'h1) && usr_ctrl[1];
         exp_finv <= usr_en && (usr_ctrl[7:4] == 4'h1) && usr_ctrl[2];
         if (usr_en) begin
            exp_op   <= usr_ctrl[4:0];
            exp_opnd <= {usr_a, usr_b, usr_c, usr_d};
         end
         if (exp_fset) begin
            exp_int_flag <= 1'b1;
         end else if (exp_fclr) begin
            exp_int_flag <= 1'b0;
         end else if (exp_finv) begin
            exp_int_flag <= ~exp_int_flag;
         end
         if (host_set) begin
            exp_host_flag <= 1'b1;
         end else if (host_clr) begin
            exp_host_flag <= 1'b0;
         end
         exp_ext_q <= {exp_ext_q[0], ext_flag};
         exp_rdy   <= resp_rdy;
         for (int k = 0; k < 4; k++) begin
            if (resp_vld[k]) begin
               exp_new[k] <= 1'b1;
               exp_dt[k]  <= resp_dt[k];
            end else if (resp_clr[k]) begin
               exp_new[k] <= 1'b0;
            end
         end
         for (int i = 0; i < PORT_QTY; i++) begin
            if (port_tvalid[i]) begin
               exp_port_new[i] <= 1'b1;
               exp_port_dt[i]  <= port_tdata[i];
            end else if (port_clr) begin
               exp_port_new[i] <= 1'b0;
            end
         end
      end
   end

   always_comb begin
      exp_status = '0;
      for (int k = 0; k < 4; k++) begin
         exp_status[4 + 2*k] = exp_rdy[k];
         exp_status[5 + 2*k] = exp_new[k];
      end
      exp_status[15] = |exp_port_new;
      for (int i = 0; i < PORT_QTY; i++) begin
         exp_status[16 + i] = exp_port_new[i];
      end
   end

   always_comb begin
      case (flg_sel)
         FLG_INT:    exp_flag = exp_int_flag;
         FLG_HOST:   exp_flag = exp_host_flag;
         FLG_EXT:    exp_flag = exp_ext_q[1];
         FLG_PORT:   exp_flag = |exp_port_new;
         FLG_NET:    exp_flag = periph_flag[0];
         FLG_COM:    exp_flag = periph_flag[1];
         FLG_P1:     exp_flag = periph_flag[2];
         default:    exp_flag = exp_new[3];
      endcase
   end

   // Port 0 low half comes out as word 0
   always_comb begin
      exp_rdata = w_dt;
      case (src_sel)
         SRC_NET:  exp_rdata = exp_dt[0];
         SRC_COM:  exp_rdata = exp_dt[1];
         SRC_P1:   exp_rdata = exp_dt[2];
         SRC_P2:   exp_rdata = exp_dt[3];
         SRC_PORT: begin
            exp_rdata[0] = exp_port_dt[0][31:0];
            exp_rdata[1] = exp_port_dt[0][63:32];
         end
         default:  exp_rdata = w_dt;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Output assertions

   task automatic report_mismatch(input string name, input logic [127:0] exp_v,
                                  input logic [127:0] act_v);
      errors++;
      $display("CHECK FAILED: %s expected 0x%0h actual 0x%0h at %0t",
               name, exp_v, act_v, $time);
   endtask

   a_en : assert property (@(posedge clk) disable iff (!rst_n) en_out == exp_en)
      else report_mismatch("qnet/qcom/qp1/qp2_en_o", 128'($sampled(exp_en)),
                           128'($sampled(en_out)));
   a_op : assert property (@(posedge clk) disable iff (!rst_n) op_out == exp_op)
      else report_mismatch("periph_op_o", 128'($sampled(exp_op)), 128'($sampled(op_out)));
   a_opnd : assert property (@(posedge clk) disable iff (!rst_n)
      {opnd_a, opnd_b, opnd_c, opnd_d} == exp_opnd)
      else report_mismatch("periph_a..d_dt_o", $sampled(exp_opnd),
                           $sampled({opnd_a, opnd_b, opnd_c, opnd_d}));
   a_status : assert property (@(posedge clk) disable iff (!rst_n) status_out == exp_status)
      else report_mismatch("status_o", 128'($sampled(exp_status)),
                           128'($sampled(status_out)));
   a_flag : assert property (@(posedge clk) disable iff (!rst_n) flag_out == exp_flag)
      else report_mismatch("flag_o", 128'($sampled(exp_flag)), 128'($sampled(flag_out)));
   a_rdata : assert property (@(posedge clk) disable iff (!rst_n) rdata_out == exp_rdata)
      else report_mismatch("core_r_dt_o", 128'($sampled(exp_rdata)),
                           128'($sampled(rdata_out)));

   ////////////////////////////////////////////////////////////
   // Stimulus

   task automatic drive_idle();
      usr_en   <= 1'b0;
      resp_vld <= '0;
      resp_clr <= '0;
      port_clr <= 1'b0;
      host_set <= 1'b0;
      host_clr <= 1'b0;
      for (int i = 0; i < PORT_QTY; i++) begin
         port_tvalid[i] <= 1'b0;
      end
   endtask

   task automatic step();
      @(posedge clk);
      drive_idle();
   endtask

   task automatic request(input usr_ctrl_t ctrl);
      step();
      usr_en   <= 1'b1;
      usr_ctrl <= ctrl;
      usr_a    <= $urandom;
      usr_b    <= $urandom;
      usr_c    <= $urandom;
      usr_d    <= $urandom;
   endtask

   task automatic drive_random();
      logic [31:0] r;
      r = $urandom;
      request(8'h00);
      usr_en <= r[0];
      // Flag class, external class, dropped classes, anything
      case (r[2:1])
         2'd0:    usr_ctrl <= {4'h1, r[11:8]};
         2'd1:    usr_ctrl <= {1'b1, r[13:12], r[20:16]};
         2'd2:    usr_ctrl <= {2'b01, r[13:12], r[11:8]};
         default: usr_ctrl <= r[31:24];
      endcase
      r = $urandom;
      resp_vld    <= r[3:0] & r[7:4];
      resp_clr    <= r[11:8] & r[15:12];
      resp_rdy    <= r[19:16];
      periph_flag <= r[22:20];
      port_clr    <= r[23] & r[24] & r[25];
      ext_flag    <= r[26];
      host_set    <= r[27] & r[28];
      host_clr    <= r[29] & r[30];
      r = $urandom;
      flg_sel <= r[2:0];
      src_sel <= r[6:3];
      for (int i = 0; i < PORT_QTY; i++) begin
         port_tvalid[i] <= r[8 + 2*i] & r[9 + 2*i];
         port_tdata[i]  <= {$urandom, $urandom};
      end
      for (int k = 0; k < 4; k++) begin
         resp_dt[k] <= {$urandom, $urandom};
      end
      w_dt <= {$urandom, $urandom};
   endtask

   task automatic run_directed();
      // P1 and P2 answer, then only P1 is cleared
      step();
      resp_vld   <= 4'b1100;
      resp_dt[2] <= {$urandom, $urandom};
      resp_dt[3] <= {$urandom, $urandom};
      src_sel    <= SRC_P1;
      step();
      resp_clr <= 4'b0100;
      src_sel  <= SRC_P2;
      flg_sel  <= FLG_P2_NEW;
      // Valid and clear in the same cycle
      step();
      resp_vld   <= 4'b0100;
      resp_clr   <= 4'b0100;
      resp_dt[2] <= {$urandom, $urandom};
      src_sel    <= SRC_P1;
      // Both ports, then the shared clear
      step();
      port_tvalid[0] <= 1'b1;
      port_tvalid[1] <= 1'b1;
      port_tdata[0]  <= {$urandom, $urandom};
      port_tdata[1]  <= {$urandom, $urandom};
      src_sel        <= SRC_PORT;
      flg_sel        <= FLG_PORT;
      step();
      port_clr <= 1'b1;
      // Internal flag priorities
      flg_sel <= FLG_INT;
      request(8'h11);
      request(8'h17);
      request(8'h16);
      request(8'h14);
      request(8'h14);
      // One request per external class
      request(8'h83);
      request(8'hA5);
      request(8'hC7);
      request(8'hE9);
      // Host set against clear
      step();
      host_set <= 1'b1;
      host_clr <= 1'b1;
      flg_sel  <= FLG_HOST;
      step();
      host_clr <= 1'b1;
      // External flag pulse through the synchronizer
      step();
      ext_flag <= 1'b1;
      flg_sel  <= FLG_EXT;
      step();
      ext_flag <= 1'b0;
      step();
      step();
      resp_rdy <= 4'b0101;
      step();
      resp_rdy <= 4'hF;
   endtask

   initial begin
      logic [31:0] seed_val;
      seed_val    = $urandom(92);
      rst_n       = 1'b0;
      usr_en      = 1'b0;
      usr_ctrl    = '0;
      usr_a       = '0;
      usr_b       = '0;
      usr_c       = '0;
      usr_d       = '0;
      resp_vld    = '0;
      resp_rdy    = 4'hF;
      resp_clr    = '0;
      periph_flag = '0;
      port_clr    = 1'b0;
      ext_flag    = 1'b0;
      host_set    = 1'b0;
      host_clr    = 1'b0;
      flg_sel     = FLG_INT;
      src_sel     = SRC_W_DT;
      w_dt        = {seed_val, ~seed_val};
      for (int k = 0; k < 4; k++) begin
         resp_dt[k] = '0;
      end
      for (int i = 0; i < PORT_QTY; i++) begin
         port_tvalid[i] = 1'b0;
         port_tdata[i]  = '0;
      end
      repeat (RST_CYC) @(posedge clk);
      rst_n <= 1'b1;
      // Sweep both selectors over the reset state
      for (int i = 0; i < 8; i++) begin
         step();
         flg_sel <= i[2:0];
         src_sel <= i[3:0];
      end
      run_directed();
      for (int n = 0; n < NUM_RAND; n++) begin
         drive_random();
      end
      repeat (4) step();
      @(posedge clk);
      $display("Checks finished with %0d errors", errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #((STIM_CYC + 50) * CLK_PERIOD);
      $display("Timeout after %0d cycles, stimulus never finished", STIM_CYC + 50);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

// ==== project.f ====
verilog/qproc_pkg.sv
verilog/usr_op_decoder.sv
verilog/resp_capture.sv
verilog/src_select.sv
verilog/qproc_periph_top.sv
verif/tb_qproc_periph.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_qproc_periph
FILELIST = project.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A crashed simulator also counts as a failure
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "Simulation FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "Failure found in $(LOG)"; \
		exit 1; \
	else \
		echo "No failure found in $(LOG)"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
